// ==== vlog.f ====
+incdir+tests
design/core_pkg.sv
design/ifu.sv
design/idu.sv
design/gpr.sv
design/exu.sv
design/core_top.sv
tests/tb_core_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_core_top -o sim_core
out=$(./obj_dir/sim_core)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

// ==== tests/core_prog.svh ====
/*
 Test program for the core and its expected commit stream:
 program words with their assembly, and one row per commit
 row layout {test id, pc, we, rd, data}
 */

`ifndef CORE_PROG_SVH
`define CORE_PROG_SVH

localparam int PROG_LEN = 26;
localparam int EXP_LEN  = 22;

localparam logic [31:0] NOP_WORD = 32'h0000_0013;

// test ids, 1 is reset and has no rows
localparam logic [2:0] T_ALU    = 3'd2;
localparam logic [2:0] T_DEP    = 3'd3;
localparam logic [2:0] T_BRANCH = 3'd4;
localparam logic [2:0] T_JAL    = 3'd5;

localparam logic [31:0] PROG [PROG_LEN] = '{
    32'h0050_0093,  // 00 addi x1, x0, 5
    32'hffd0_0113,  // 04 addi x2, x0, -3
    32'h0020_81b3,  // 08 add  x3, x1, x2
    32'h4020_8233,  // 0c sub  x4, x1, x2
    32'h0020_f2b3,  // 10 and  x5, x1, x2
    32'h0020_e333,  // 14 or   x6, x1, x2
    32'h0020_c3b3,  // 18 xor  x7, x1, x2
    32'h0f03_f413,  // 1c andi x8, x7, 0x0f0
    32'hff00_e493,  // 20 ori  x9, x1, -16
    32'h7ff0_c513,  // 24 xori x10, x1, 0x7ff
    32'h1234_55b7,  // 28 lui  x11, 0x12345
    32'h6785_8593,  // 2c addi x11, x11, 0x678
    32'h0010_8663,  // 30 beq  x1, x1, +12
    32'h0010_0613,  // 34 addi x12, x0, 1   never commits
    32'h0020_0613,  // 38 addi x12, x0, 2   never commits
    32'h0020_9663,  // 3c bne  x1, x2, +12
    32'h0010_0693,  // 40 addi x13, x0, 1   never commits
    32'h0020_0693,  // 44 addi x13, x0, 2   never commits
    32'h0020_8463,  // 48 beq  x1, x2, +8   not taken
    32'h0010_9463,  // 4c bne  x1, x1, +8   not taken
    32'h00c0_076f,  // 50 jal  x14, +12
    32'h0030_0613,  // 54 addi x12, x0, 3   never commits
    32'h0040_0613,  // 58 addi x12, x0, 4   never commits
    32'h0070_8013,  // 5c addi x0, x1, 7
    32'h0010_07b3,  // 60 add  x15, x0, x1
    32'h0000_006f   // 64 jal  x0, 0
};

localparam logic [72:0] EXP [EXP_LEN] = '{
    {T_ALU,    32'h0000_0000, 1'b1, 5'd1,  32'h0000_0005},
    {T_ALU,    32'h0000_0004, 1'b1, 5'd2,  32'hffff_fffd},
    {T_DEP,    32'h0000_0008, 1'b1, 5'd3,  32'h0000_0002},
    {T_ALU,    32'h0000_000c, 1'b1, 5'd4,  32'h0000_0008},
    {T_ALU,    32'h0000_0010, 1'b1, 5'd5,  32'h0000_0005},
    {T_ALU,    32'h0000_0014, 1'b1, 5'd6,  32'hffff_fffd},
    {T_ALU,    32'h0000_0018, 1'b1, 5'd7,  32'hffff_fff8},
    {T_DEP,    32'h0000_001c, 1'b1, 5'd8,  32'h0000_00f0},
    {T_ALU,    32'h0000_0020, 1'b1, 5'd9,  32'hffff_fff5},
    {T_ALU,    32'h0000_0024, 1'b1, 5'd10, 32'h0000_07fa},
    {T_ALU,    32'h0000_0028, 1'b1, 5'd11, 32'h1234_5000},
    {T_DEP,    32'h0000_002c, 1'b1, 5'd11, 32'h1234_5678},
    {T_BRANCH, 32'h0000_0030, 1'b0, 5'd0,  32'h0000_0000},
    {T_BRANCH, 32'h0000_003c, 1'b0, 5'd0,  32'h0000_0000},
    {T_BRANCH, 32'h0000_0048, 1'b0, 5'd0,  32'h0000_0000},
    {T_BRANCH, 32'h0000_004c, 1'b0, 5'd0,  32'h0000_0000},
    {T_JAL,    32'h0000_0050, 1'b1, 5'd14, 32'h0000_0054},
    {T_JAL,    32'h0000_005c, 1'b1, 5'd0,  32'h0000_000c},
    {T_JAL,    32'h0000_0060, 1'b1, 5'd15, 32'h0000_0005},
    {T_JAL,    32'h0000_0064, 1'b1, 5'd0,  32'h0000_0068},
    {T_JAL,    32'h0000_0064, 1'b1, 5'd0,  32'h0000_0068},
    {T_JAL,    32'h0000_0064, 1'b1, 5'd0,  32'h0000_0068}
};

`endif

// ==== tests/tb_core_top.sv ====
/*
 Testbench for core_top:
 clock and reset, combinational instruction memory model,
 commit stream checks against the expected table, timeout and report
 */

`timescale 1ns/1ps

module tb_core_top;

    `include "core_prog.svh"

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_CYCLES   = RESET_CYCLES + 3 * EXP_LEN + 20;

    logic        clk;
    logic        arst_n;
    logic [31:0] inst;
    logic [31:0] inst_addr;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic        commit_we;
    logic [4:0]  commit_rd;
    logic [31:0] commit_wdata;

    int   idx        = 0;
    int   cycles     = 0;
    int   mismatches = 0;
    int   failures   = 0;
    logic timed_out  = 1'b0;

    logic [72:0] exp_row;
    logic [2:0]  exp_test;
    logic [31:0] exp_pc;
    logic        exp_we;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        checking;

    core_top u_dut (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .inst_i        (inst),
        .inst_addr_o   (inst_addr),
        .commit_valid_o(commit_valid),
        .commit_pc_o   (commit_pc),
        .commit_we_o   (commit_we),
        .commit_rd_o   (commit_rd),
        .commit_wdata_o(commit_wdata)
    );

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "reset";
            T_ALU:   return "alu_ops";
            T_DEP:   return "dependency";
            T_BRANCH: return "branches";
            T_JAL:   return "jal_x0";
            default: return "unknown";
        endcase
    endfunction

    // words past the program read as nop
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int widx;
        widx = int'(addr >> 2);
        if (widx < PROG_LEN) begin
            return PROG[widx];
        end
        return NOP_WORD;
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        mismatches++;
        $display("Mismatch %s: %s expected %h, actual %h", test, what, expected, actual);
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("error: %s", msg);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memory answers the address seen since the last rising edge
    initial begin
        inst = NOP_WORD;
        forever begin
            @(negedge clk);
            inst = fetch_word(inst_addr);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx <= 0;
        end else if (commit_valid && idx < EXP_LEN) begin
            idx <= idx + 1;
        end
    end

    assign exp_row  = (idx < EXP_LEN) ? EXP[idx] : '0;
    assign exp_test = exp_row[72:70];
    assign exp_pc   = exp_row[69:38];
    assign exp_we   = exp_row[37];
    assign exp_rd   = exp_row[36:32];
    assign exp_data = exp_row[31:0];
    assign checking = commit_valid && (idx < EXP_LEN);

    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !commit_valid)
        else report_failure("commit_valid_o high while reset is asserted");

    a_first_fetch: assert property (@(posedge clk) $rose(arst_n) |-> inst_addr == 32'h0)
        else report_mismatch("reset", "first fetch address", 32'h0, $sampled(inst_addr));

    a_commit_pc: assert property (
        @(posedge clk) disable iff (!arst_n)
        checking |-> commit_pc == exp_pc
    ) else report_mismatch(test_name($sampled(exp_test)), "commit pc",
                           $sampled(exp_pc), $sampled(commit_pc));

    a_commit_we: assert property (
        @(posedge clk) disable iff (!arst_n)
        checking |-> commit_we == exp_we
    ) else report_mismatch(test_name($sampled(exp_test)), "commit we",
                           32'($sampled(exp_we)), 32'($sampled(commit_we)));

    a_commit_rd: assert property (
        @(posedge clk) disable iff (!arst_n)
        (checking && exp_we) |-> commit_rd == exp_rd
    ) else report_mismatch(test_name($sampled(exp_test)), "commit rd",
                           32'($sampled(exp_rd)), 32'($sampled(commit_rd)));

    a_commit_data: assert property (
        @(posedge clk) disable iff (!arst_n)
        (checking && exp_we) |-> commit_wdata == exp_data
    ) else report_mismatch(test_name($sampled(exp_test)), "commit data",
                           $sampled(exp_data), $sampled(commit_wdata));

    a_no_extra: assert property (
        @(posedge clk) disable iff (!arst_n)
        commit_valid |-> idx < EXP_LEN
    ) else report_failure("commit seen after the expected table ended");

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        while (idx < EXP_LEN && cycles < MAX_CYCLES) begin
            @(negedge clk);
        end
        if (idx < EXP_LEN) begin
            timed_out = 1'b1;
            $display("error: timeout after %0d cycles, only %0d of %0d commits seen",
                     cycles, idx, EXP_LEN);
        end else begin
            // the two slots behind the final jal must stay empty
            repeat (2) @(negedge clk);
        end
        $display("%0d mismatches, %0d other failures, timeout %0d",
                 mismatches, failures, timed_out);
        if (mismatches == 0 && failures == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== design/core_top.sv ====
/*
 Core top level:
 fetch, decode, register file and execute wired
 into a three-stage pipeline with fetch and commit ports
 */

`timescale 1ns/1ps

module core_top (
    input  logic                            clk,
    input  logic                            arst_n_i,

    input  logic [core_pkg::XLEN-1:0]       inst_i,
    output logic [core_pkg::XLEN-1:0]       inst_addr_o,

    output logic                            commit_valid_o,
    output logic [core_pkg::XLEN-1:0]       commit_pc_o,
    output logic                            commit_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0] commit_rd_o,
    output logic [core_pkg::XLEN-1:0]       commit_wdata_o
);

    // IF/ID
    logic                            if_valid;
    logic [core_pkg::XLEN-1:0]       if_inst;
    logic [core_pkg::XLEN-1:0]       if_pc;

    // register file read
    logic [core_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [core_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [core_pkg::XLEN-1:0]       rs1_data;
    logic [core_pkg::XLEN-1:0]       rs2_data;

    // ID/EX
    logic                            ex_valid;
    logic [core_pkg::XLEN-1:0]       ex_pc;
    core_pkg::alu_op_e               ex_alu_op;
    logic [core_pkg::XLEN-1:0]       ex_op_a;
    logic [core_pkg::XLEN-1:0]       ex_op_b;
    logic [core_pkg::XLEN-1:0]       ex_imm;
    logic [core_pkg::REG_ADDR_W-1:0] ex_rd;
    logic                            ex_we;
    logic                            ex_branch;
    logic                            ex_bne;
    logic                            ex_jal;

    // EX results
    logic                            jump_flag;
    logic [core_pkg::XLEN-1:0]       jump_addr;

    ifu u_ifu (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .jump_flag_i(jump_flag),
        .jump_addr_i(jump_addr),
        .inst_i     (inst_i),
        .inst_addr_o(inst_addr_o),
        .if_valid_o (if_valid),
        .if_inst_o  (if_inst),
        .if_pc_o    (if_pc)
    );

    idu u_idu (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .jump_flag_i(jump_flag),
        .if_valid_i (if_valid),
        .if_inst_i  (if_inst),
        .if_pc_i    (if_pc),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ex_valid_o (ex_valid),
        .ex_pc_o    (ex_pc),
        .ex_alu_op_o(ex_alu_op),
        .ex_op_a_o  (ex_op_a),
        .ex_op_b_o  (ex_op_b),
        .ex_imm_o   (ex_imm),
        .ex_rd_o    (ex_rd),
        .ex_we_o    (ex_we),
        .ex_branch_o(ex_branch),
        .ex_bne_o   (ex_bne),
        .ex_jal_o   (ex_jal)
    );

    // write port is the commit port
    gpr u_gpr (
        .clk     (clk),
        .arst_n_i(arst_n_i),
        .we_i    (commit_we_o),
        .waddr_i (commit_rd_o),
        .wdata_i (commit_wdata_o),
        .raddr1_i(rs1_addr),
        .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

    exu u_exu (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .ex_valid_i    (ex_valid),
        .ex_pc_i       (ex_pc),
        .ex_alu_op_i   (ex_alu_op),
        .ex_op_a_i     (ex_op_a),
        .ex_op_b_i     (ex_op_b),
        .ex_imm_i      (ex_imm),
        .ex_rd_i       (ex_rd),
        .ex_we_i       (ex_we),
        .ex_branch_i   (ex_branch),
        .ex_bne_i      (ex_bne),
        .ex_jal_i      (ex_jal),
        .jump_flag_o   (jump_flag),
        .jump_addr_o   (jump_addr),
        .rd_we_o       (commit_we_o),
        .rd_addr_o     (commit_rd_o),
        .rd_wdata_o    (commit_wdata_o),
        .commit_valid_o(commit_valid_o),
        .commit_pc_o   (commit_pc_o)
    );

endmodule

// ==== design/exu.sv ====
/*
 Execute unit:
 ALU, BEQ/BNE compare, jump target and JAL link value,
 register write-back and commit outputs
 */

`timescale 1ns/1ps

module exu
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n_i,

    input  logic                  ex_valid_i,
    input  logic [XLEN-1:0]       ex_pc_i,
    input  alu_op_e               ex_alu_op_i,
    input  logic [XLEN-1:0]       ex_op_a_i,
    input  logic [XLEN-1:0]       ex_op_b_i,
    input  logic [XLEN-1:0]       ex_imm_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_i,
    input  logic                  ex_we_i,
    input  logic                  ex_branch_i,
    input  logic                  ex_bne_i,
    input  logic                  ex_jal_i,

    output logic                  jump_flag_o,
    output logic [XLEN-1:0]       jump_addr_o,

    output logic                  rd_we_o,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic [XLEN-1:0]       rd_wdata_o,

    output logic                  commit_valid_o,
    output logic [XLEN-1:0]       commit_pc_o
);

    logic [XLEN-1:0] alu_res;
    logic            op_equal;
    logic            br_taken;

    always_comb begin
        case (ex_alu_op_i)
            ALU_ADD:    alu_res = ex_op_a_i + ex_op_b_i;
            ALU_SUB:    alu_res = ex_op_a_i - ex_op_b_i;
            ALU_AND:    alu_res = ex_op_a_i & ex_op_b_i;
            ALU_OR:     alu_res = ex_op_a_i | ex_op_b_i;
            ALU_XOR:    alu_res = ex_op_a_i ^ ex_op_b_i;
            ALU_PASS_B: alu_res = ex_op_b_i;
            default:    alu_res = ex_op_a_i + ex_op_b_i;
        endcase
    end

    // op_b holds rs2 for branches
    assign op_equal = (ex_op_a_i == ex_op_b_i);
    assign br_taken = ex_branch_i && (ex_bne_i ? !op_equal : op_equal);

    assign jump_flag_o = ex_valid_i && (br_taken || ex_jal_i);
    assign jump_addr_o = ex_pc_i + ex_imm_i;

    // link value for JAL
    assign rd_we_o    = ex_valid_i && ex_we_i;
    assign rd_addr_o  = ex_rd_i;
    assign rd_wdata_o = ex_jal_i ? ex_pc_i + INST_BYTES : alu_res;

    assign commit_valid_o = ex_valid_i;
    assign commit_pc_o    = ex_pc_i;

    a_target_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        jump_flag_o |-> jump_addr_o[1:0] == 2'b00
    ) else $error("exu: jump target %h not word aligned", jump_addr_o);

    // the slot right behind a jump was flushed in ID
    a_flush_next: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        jump_flag_o |=> !commit_valid_o
    ) else $error("exu: instruction behind a jump committed");

endmodule

// ==== design/gpr.sv ====
/*
 General-purpose register file:
 32 x XLEN, x0 hard-wired to zero,
 two combinational read ports with write-through
 */

`timescale 1ns/1ps

module gpr
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n_i,

    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,

    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o
);

    logic [XLEN-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // bypass EX write data so ID sees it in the same cycle
    assign rdata1_o = (raddr1_i == '0)                ? '0      :
                      (we_i && waddr_i == raddr1_i)   ? wdata_i :
                                                        regs_q[raddr1_i];

    assign rdata2_o = (raddr2_i == '0)                ? '0      :
                      (we_i && waddr_i == raddr2_i)   ? wdata_i :
                                                        regs_q[raddr2_i];

    a_wdata_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        we_i |-> !$isunknown(wdata_i)
    ) else $error("gpr: unknown write data to x%0d", waddr_i);

endmodule

// ==== design/idu.sv ====
/*
 Instruction decode unit:
 register file read addresses, immediate generation per format,
 ALU op and operand selection, and the ID/EX register
 */

`timescale 1ns/1ps

module idu
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n_i,

    input  logic                  jump_flag_i,

    input  logic                  if_valid_i,
    input  logic [XLEN-1:0]       if_inst_i,
    input  logic [XLEN-1:0]       if_pc_i,

    // register file read port
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,

    // execute fields
    output logic                  ex_valid_o,
    output logic [XLEN-1:0]       ex_pc_o,
    output alu_op_e               ex_alu_op_o,
    output logic [XLEN-1:0]       ex_op_a_o,
    output logic [XLEN-1:0]       ex_op_b_o,
    output logic [XLEN-1:0]       ex_imm_o,
    output logic [REG_ADDR_W-1:0] ex_rd_o,
    output logic                  ex_we_o,
    output logic                  ex_branch_o,
    output logic                  ex_bne_o,
    output logic                  ex_jal_o
);

    rv_inst_u        inst;
    logic            fire;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    alu_op_e         dec_alu_op;
    logic            dec_use_imm;
    logic [XLEN-1:0] dec_imm;
    logic            dec_we;
    logic            dec_branch;
    logic            dec_bne;
    logic            dec_jal;

    assign inst = if_inst_i;
    assign fire = if_valid_i && !jump_flag_i;

    assign rs1_addr_o = inst.r.rs1;
    assign rs2_addr_o = inst.r.rs2;

    // sign-extended immediates
    assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
    assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                    inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    assign imm_u = {inst.u.imm_31_12, 12'b0};
    assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                    inst.j.imm_11, inst.j.imm_10_1, 1'b0};

    always_comb begin
        dec_alu_op  = ALU_ADD;
        dec_use_imm = 1'b0;
        dec_imm     = '0;
        dec_we      = 1'b0;
        dec_branch  = 1'b0;
        dec_bne     = 1'b0;
        dec_jal     = 1'b0;
        case (inst.r.opcode)
            OPC_OP: begin
                dec_we = 1'b1;
                case (inst.r.funct3)
                    F3_ADD_SUB: dec_alu_op = (inst.r.funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_XOR:     dec_alu_op = ALU_XOR;
                    F3_OR:      dec_alu_op = ALU_OR;
                    F3_AND:     dec_alu_op = ALU_AND;
                    default:    dec_we = 1'b0;
                endcase
                // only SUB uses the alternate funct7
                if (inst.r.funct7 != F7_BASE &&
                    !(inst.r.funct7 == F7_ALT && inst.r.funct3 == F3_ADD_SUB)) begin
                    dec_we = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                dec_we      = 1'b1;
                dec_use_imm = 1'b1;
                dec_imm     = imm_i;
                case (inst.i.funct3)
                    F3_ADD_SUB: dec_alu_op = ALU_ADD;
                    F3_XOR:     dec_alu_op = ALU_XOR;
                    F3_OR:      dec_alu_op = ALU_OR;
                    F3_AND:     dec_alu_op = ALU_AND;
                    default:    dec_we = 1'b0;
                endcase
            end
            OPC_LUI: begin
                dec_we      = 1'b1;
                dec_use_imm = 1'b1;
                dec_imm     = imm_u;
                dec_alu_op  = ALU_PASS_B;
            end
            OPC_BRANCH: begin
                dec_imm    = imm_b;
                dec_branch = (inst.b.funct3 == F3_BEQ) || (inst.b.funct3 == F3_BNE);
                dec_bne    = (inst.b.funct3 == F3_BNE);
            end
            OPC_JAL: begin
                dec_we  = 1'b1;
                dec_jal = 1'b1;
                dec_imm = imm_j;
            end
            // anything else retires as a no-op
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o  <= 1'b0;
            ex_we_o     <= 1'b0;
            ex_branch_o <= 1'b0;
            ex_jal_o    <= 1'b0;
        end else begin
            ex_valid_o  <= fire;
            ex_we_o     <= fire && dec_we;
            ex_branch_o <= fire && dec_branch;
            ex_jal_o    <= fire && dec_jal;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o     <= if_pc_i;
        ex_alu_op_o <= dec_alu_op;
        ex_op_a_o   <= rs1_data_i;
        ex_op_b_o   <= dec_use_imm ? dec_imm : rs2_data_i;
        ex_imm_o    <= dec_imm;
        ex_rd_o     <= inst.r.rd;
        ex_bne_o    <= dec_bne;
    end

    // flushed or empty slots must reach EX without a register write
    a_bubble_no_we: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (!if_valid_i || jump_flag_i) |=> (!ex_valid_o && !ex_we_o)
    ) else $error("idu: bubble in EX carries a write enable");

endmodule

// ==== design/ifu.sv ====
/*
 Instruction fetch unit:
 pc register with next-pc selection (pc+4 or jump target)
 and the IF/ID register holding the fetched word and its pc
 */

`timescale 1ns/1ps

module ifu
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n_i,

    input  logic            jump_flag_i,
    input  logic [XLEN-1:0] jump_addr_i,

    // combinational instruction memory port
    input  logic [XLEN-1:0] inst_i,
    output logic [XLEN-1:0] inst_addr_o,

    output logic            if_valid_o,
    output logic [XLEN-1:0] if_inst_o,
    output logic [XLEN-1:0] if_pc_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;

    // a resolved jump in EX overrides sequential fetch
    assign pc_next     = jump_flag_i ? jump_addr_i : pc_q + INST_BYTES;
    assign inst_addr_o = pc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q       <= RESET_PC;
            if_valid_o <= 1'b0;
        end else begin
            pc_q       <= pc_next;
            // word fetched this cycle is on the wrong path
            if_valid_o <= !jump_flag_i;
        end
    end

    always_ff @(posedge clk) begin
        if_inst_o <= inst_i;
        if_pc_o   <= pc_q;
    end

    // targets come from EX, so this also covers the decoded offsets
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        inst_addr_o[1:0] == 2'b00
    ) else $error("ifu: fetch address %h not word aligned", inst_addr_o);

endmodule

// ==== design/core_pkg.sv ====
/*
 Shared definitions of the RV32I subset core:
 data and register index widths, reset pc, fetch step,
 major opcodes, funct3/funct7 codes, ALU operation enum
 and the packed instruction word union
 */

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] RESET_PC   = 32'h0000_0000;
    localparam logic [XLEN-1:0] INST_BYTES = 32'd4;

    // major opcodes of the kept instructions
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // funct3 for OP / OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7, ALT selects SUB
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // one instruction word, seen in each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_inst_u;

endpackage
